// ==== common/drumSynth_params.svh ====
`ifndef DRUMSYNTH_PARAMS_SVH
`define DRUMSYNTH_PARAMS_SVH

// Mesh geometry
`define MESH_ROWS 5                   // Grid rows
`define MESH_COLS 5                   // Grid columns

// Fixed point, 1 sign bit plus fraction
`define FRAC_BITS 17                  // Fraction bits of displacement and coefs

// Damping per key, 17-bit fraction
`define ETA_TONE1 18'h0_0003          // Key 1, long ring
`define ETA_TONE2 18'h0_0400          // Key 2, short thud
`define ETA_TONE3 18'h0_0010          // Key 3, medium

// Tension feedback
`define RHO_0 18'h0_2000              // Base rho, 1/16
`define RHO_MAX 18'h0_8000            // Upper clamp, 1/4 keeps mesh stable
`define RHO_SHIFT 20                  // Scale of squared centre displacement

// Excitation and timing
`define STRIKE_AMP 18'h1_0000         // Centre hit, 0.5
`define MESH_STEP_DIV 4               // Clocks per mesh step
`define BLINK_STEPS 64                // Mesh steps per LED toggle

`endif

// ==== common/ioPkg.sv ====
package ioPkg;
  // Seven-segment pattern, gfedcba, segment on when low
  typedef logic [6:0] segT;

  // Audio sample for the codec path, two's complement
  typedef logic signed [15:0] sampleT;

  // Keys 1 to 3, pressed when low
  typedef logic [2:0] keyT;

  localparam segT SEG_BLANK = 7'h7F;  // All segments dark
  localparam keyT KEYS_UP = 3'b111;   // Nothing pressed
endpackage

// ==== common/meshPkg.sv ====
`include "drumSynth_params.svh"

package meshPkg;
  typedef logic signed [`FRAC_BITS:0] fixT;       // Displacement, s1.17
  typedef logic [`FRAC_BITS:0] coefT;             // rho and eta, u1.17
  typedef logic signed [`FRAC_BITS+2:0] nbrSumT;  // Sum of four neighbours
  typedef logic signed [47:0] prodT;              // Full-width product

  localparam fixT FIX_MAX = {1'b0, {`FRAC_BITS{1'b1}}};  // Just under +1
  localparam fixT FIX_MIN = {1'b1, {`FRAC_BITS{1'b0}}};  // Exactly -1
  localparam coefT COEF_ONE = coefT'(1) << `FRAC_BITS;   // 1.0 as coefficient

  // Product back to fixT, arithmetic shift then clip
  function automatic fixT satShift(input prodT p);
    prodT s;
    s = p >>> `FRAC_BITS;
    if (s > FIX_MAX) return FIX_MAX;
    if (s < FIX_MIN) return FIX_MIN;
    return s[`FRAC_BITS:0];
  endfunction
endpackage

// ==== drumSynth.f ====
+incdir+common
+incdir+verification
common/meshPkg.sv
common/ioPkg.sv
mesh/meshNode.sv
mesh/compMesh.sv
src/toneSelect.sv
src/rhoEffective.sv
src/outputStage.sv
src/drumSynth.sv
verification/drumSynthTb.sv

// ==== mesh/compMesh.sv ====
`include "drumSynth_params.svh"

module compMesh import meshPkg::*; #(
  parameter int rows = 5,
  parameter int cols = 5
) (
  input  logic validOut,
  input  logic arstN,
  input  logic strike,        // Restart the mesh
  input  coefT eta,
  input  coefT rhoEff,
  output fixT  uMid,          // Centre displacement
  output logic stepDone       // New step visible on uMid
);

  localparam int midRow = rows / 2;
  localparam int midCol = cols / 2;
  localparam int divW = $clog2(`MESH_STEP_DIV + 1);
  localparam logic [divW-1:0] divLast = divW'(`MESH_STEP_DIV - 1);
  localparam logic [divW-1:0] divRestart = divW'(1);  // Load edge is clock one

  // Grid with a ring of zeros around it
  fixT uPad [rows+2][cols+2];

  logic [divW-1:0] divCnt;    // Clocks into current step
  logic step;

  assign step = (divCnt == divLast);

  always_ff @(posedge validOut or negedge arstN) begin
    if (!arstN) begin
      divCnt   <= '0;
      stepDone <= 1'b0;
    end else if (strike) begin
      divCnt   <= divRestart;   // Count from the load
      stepDone <= 1'b0;         // Load overrides a coinciding step
    end else begin
      divCnt   <= step ? '0 : divCnt + 1'b1;
      stepDone <= step;
    end
  end

  // Fixed boundary, top and bottom rows
  for (genvar c = 0; c < cols + 2; c++) begin : genEdgeTb
    assign uPad[0][c]      = '0;
    assign uPad[rows+1][c] = '0;
  end

  // Left and right columns
  for (genvar r = 1; r <= rows; r++) begin : genEdgeLr
    assign uPad[r][0]      = '0;
    assign uPad[r][cols+1] = '0;
  end

  for (genvar r = 0; r < rows; r++) begin : genRow
    for (genvar c = 0; c < cols; c++) begin : genCol
      nbrSumT nSum;
      fixT loadVal;

      // Node r,c sits at r+1,c+1 in the padded grid
      assign nSum = uPad[r][c+1] + uPad[r+2][c+1]
                  + uPad[r+1][c] + uPad[r+1][c+2];

      // Only centre gets hit
      assign loadVal = (r == midRow && c == midCol) ? fixT'(`STRIKE_AMP) : fixT'(0);

      meshNode node (
        .validOut   (validOut),
        .arstN      (arstN),
        .step       (step),
        .load       (strike),
        .loadValue  (loadVal),
        .neighborSum(nSum),
        .rho        (rhoEff),
        .eta        (eta),
        .u          (uPad[r+1][c+1])
      );
    end
  end

  assign uMid = uPad[midRow+1][midCol+1];  // Audio tap

endmodule

// ==== mesh/meshNode.sv ====
module meshNode import meshPkg::*; (
  input  logic   validOut,
  input  logic   arstN,
  input  logic   step,          // Advance one time step
  input  logic   load,          // Strike loading, wins over step
  input  fixT    loadValue,
  input  nbrSumT neighborSum,   // Up + down + left + right
  input  coefT   rho,
  input  coefT   eta,
  output fixT    u              // Present displacement
);

  fixT uPrev;                                 // Displacement one step back
  coefT dampCoef;                             // 1 - eta
  logic signed [$bits(coefT):0] rhoS;         // Coefs with a zero sign bit
  logic signed [$bits(coefT):0] dampS;
  logic signed [$bits(nbrSumT):0] lap;        // Discrete Laplacian
  logic signed [$bits(fixT)+2:0] preSum;      // Sum before damping
  prodT pRho;
  prodT pPrev;
  prodT pOut;
  fixT rhoTerm;
  fixT prevTerm;
  fixT uNext;

  always_comb begin
    dampCoef = COEF_ONE - eta;
    rhoS     = {1'b0, rho};
    dampS    = {1'b0, dampCoef};
    lap      = neighborSum - (u <<< 2);       // Neighbours minus 4u
    pRho     = lap * rhoS;                    // Full width, signed
    rhoTerm  = satShift(pRho);
    pPrev    = uPrev * dampS;
    prevTerm = satShift(pPrev);               // (1 - eta) uPrev
    preSum   = rhoTerm + (u <<< 1) - prevTerm;
    pOut     = preSum * dampS;
    uNext    = satShift(pOut);                // Damped new value
  end

  always_ff @(posedge validOut or negedge arstN) begin
    if (!arstN) begin
      u     <= '0;
      uPrev <= '0;
    end else if (load) begin
      u     <= loadValue;                     // Start at rest shape
      uPrev <= loadValue;                     // Zero initial velocity
    end else if (step) begin
      uPrev <= u;
      u     <= uNext;
    end
  end

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Build and run the drumSynth testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f drumSynth.f --top-module drumSynthTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VdrumSynthTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
else
  echo "Pass message not found in $LOG"
  exit 1
fi

// ==== src/drumSynth.sv ====
`include "drumSynth_params.svh"

module drumSynth import meshPkg::*, ioPkg::*; (
  input  logic   validOut,
  input  logic   arstN,
  input  keyT    keyN,
  input  logic   tensionEn,
  output segT    hex0,
  output segT    hex1,
  output segT    hex2,
  output segT    hex3,
  output segT    hex4,
  output sampleT audioSample,
  output logic   sampleStrobe,
  output logic   ledBlink,
  output logic   ledTone
);

  coefT eta;
  coefT rhoEff;
  fixT  uMid;
  logic strike;
  logic toneHeld;
  logic stepDone;

  toneSelect toneSelect_inst (.validOut, .arstN, .keyN, .eta, .strike, .toneHeld);

  compMesh #(
    .rows(`MESH_ROWS),
    .cols(`MESH_COLS)
  ) compMesh_inst (.validOut, .arstN, .strike, .eta, .rhoEff, .uMid, .stepDone);

  rhoEffective rhoEffective_inst (.validOut, .arstN, .tensionEn, .uMid, .stepDone, .rhoEff);

  outputStage outputStage_inst (
    .validOut, .arstN, .eta, .uMid, .stepDone, .toneHeld,
    .hex0, .hex1, .hex2, .hex3, .hex4,
    .audioSample, .sampleStrobe, .ledBlink, .ledTone
  );

endmodule

// ==== src/outputStage.sv ====
`include "drumSynth_params.svh"

module outputStage import meshPkg::*, ioPkg::*; (
  input  logic   validOut,
  input  logic   arstN,
  input  coefT   eta,
  input  fixT    uMid,
  input  logic   stepDone,
  input  logic   toneHeld,
  output segT    hex0,          // eta[3:0]
  output segT    hex1,
  output segT    hex2,
  output segT    hex3,
  output segT    hex4,          // eta[17:16]
  output sampleT audioSample,
  output logic   sampleStrobe,  // audioSample just updated
  output logic   ledBlink,
  output logic   ledTone
);

  localparam int blinkW = $clog2(`BLINK_STEPS);

  logic [blinkW-1:0] blinkCnt;  // Steps since last toggle

  function automatic segT hexToSeg(input logic [3:0] n);
    case (n)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;       // Lower-case b
      4'hC: return 7'h46;
      4'hD: return 7'h21;       // Lower-case d
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  assign hex0 = hexToSeg(eta[3:0]);
  assign hex1 = hexToSeg(eta[7:4]);
  assign hex2 = hexToSeg(eta[11:8]);
  assign hex3 = hexToSeg(eta[15:12]);
  assign hex4 = hexToSeg({2'b00, eta[17:16]});  // Only two bits left

  always_ff @(posedge validOut or negedge arstN) begin
    if (!arstN) begin
      audioSample  <= '0;
      sampleStrobe <= 1'b0;
      blinkCnt     <= '0;
      ledBlink     <= 1'b0;
      ledTone      <= 1'b0;
    end else begin
      sampleStrobe <= stepDone;
      ledTone      <= toneHeld;
      if (stepDone) begin
        audioSample <= uMid[`FRAC_BITS -: 16];  // Top 16 bits
        blinkCnt    <= blinkCnt + 1'b1;         // Wraps at BLINK_STEPS
        if (blinkCnt == blinkW'(`BLINK_STEPS - 1)) ledBlink <= ~ledBlink;
      end
    end
  end

endmodule

// ==== src/rhoEffective.sv ====
`include "drumSynth_params.svh"

module rhoEffective import meshPkg::*; (
  input  logic validOut,
  input  logic arstN,
  input  logic tensionEn,     // Switch, feedback on
  input  fixT  uMid,
  input  logic stepDone,
  output coefT rhoEff         // Used by the following step
);

  logic signed [2*$bits(fixT)-1:0] sq;    // uMid squared, never negative
  logic [$bits(coefT)+1:0] rhoSum;        // Headroom for the add
  coefT rhoNext;

  assign sq = uMid * uMid;
  assign rhoSum = ($bits(rhoSum))'(sq >>> `RHO_SHIFT) + ($bits(rhoSum))'(`RHO_0);

  always_comb begin
    if (!tensionEn) begin
      rhoNext = `RHO_0;                   // Plain membrane
    end else if (rhoSum > ($bits(rhoSum))'(`RHO_MAX)) begin
      rhoNext = `RHO_MAX;                 // Keep update stable
    end else begin
      rhoNext = rhoSum[$bits(coefT)-1:0];
    end
  end

  always_ff @(posedge validOut or negedge arstN) begin
    if (!arstN) begin
      rhoEff <= `RHO_0;
    end else if (stepDone) begin
      rhoEff <= rhoNext;                  // Once per mesh step
    end
  end

endmodule

// ==== src/toneSelect.sv ====
`include "drumSynth_params.svh"

module toneSelect import meshPkg::*, ioPkg::*; (
  input  logic validOut,
  input  logic arstN,
  input  keyT  keyN,          // Active-low keys 1 to 3
  output coefT eta,           // Latched damping
  output logic strike,        // One clock per new press
  output logic toneHeld       // Any key down
);

  keyT prevKeyN;              // Keys one clock ago
  logic newPress;

  assign newPress = |(~keyN & prevKeyN);  // Released to pressed
  assign toneHeld = ~&keyN;

  always_ff @(posedge validOut or negedge arstN) begin
    if (!arstN) begin
      prevKeyN <= KEYS_UP;
      strike   <= 1'b0;
      eta      <= '0;
    end else begin
      prevKeyN <= keyN;
      strike   <= newPress;
      if (newPress) begin
        // Lowest-numbered key wins
        if (!keyN[0]) eta <= `ETA_TONE1;
        else if (!keyN[1]) eta <= `ETA_TONE2;
        else if (!keyN[2]) eta <= `ETA_TONE3;
      end
    end
  end

endmodule

// ==== verification/drumModel.svh ====
`ifndef DRUMMODEL_SVH
`define DRUMMODEL_SVH

longint mU [`MESH_ROWS][`MESH_COLS];      // Present displacement, s.17
longint mPrev [`MESH_ROWS][`MESH_COLS];   // One step back
longint mEta;                             // Damping of the current run
longint mRho = `RHO_0;                    // rho for the coming step
int checkCount;
int errorCount;

// Standard active-high gfedcba codes, panel wants them inverted
function automatic segT segFor(input logic [3:0] nib);
  logic [6:0] lit;
  case (nib)
    4'h0: lit = 7'h3F;
    4'h1: lit = 7'h06;
    4'h2: lit = 7'h5B;
    4'h3: lit = 7'h4F;
    4'h4: lit = 7'h66;
    4'h5: lit = 7'h6D;
    4'h6: lit = 7'h7D;
    4'h7: lit = 7'h07;
    4'h8: lit = 7'h7F;
    4'h9: lit = 7'h6F;
    4'hA: lit = 7'h77;
    4'hB: lit = 7'h7C;                    // b
    4'hC: lit = 7'h39;
    4'hD: lit = 7'h5E;                    // d
    4'hE: lit = 7'h79;
    default: lit = 7'h71;
  endcase
  return ~lit;
endfunction

// Full product down to s.17 with clipping
function automatic longint fixClip(input longint p);
  longint s;
  longint hi;
  hi = (longint'(1) <<< `FRAC_BITS) - 1;
  s = p >>> `FRAC_BITS;                   // Floor, like an arithmetic shift
  if (s > hi) s = hi;
  if (s < -hi - 1) s = -hi - 1;
  return s;
endfunction

function automatic longint cellAt(input int r, input int c);
  if (r < 0 || r >= `MESH_ROWS || c < 0 || c >= `MESH_COLS) return 0;  // Clamped rim
  return mU[r][c];
endfunction

task automatic modelLoad(input coefT eta);
  for (int r = 0; r < `MESH_ROWS; r++) begin
    for (int c = 0; c < `MESH_COLS; c++) begin
      mU[r][c] = 0;
      mPrev[r][c] = 0;
    end
  end
  mU[`MESH_ROWS / 2][`MESH_COLS / 2] = `STRIKE_AMP;     // Hit at rest
  mPrev[`MESH_ROWS / 2][`MESH_COLS / 2] = `STRIKE_AMP;
  mEta = eta;                                            // rho carries over
endtask

// One damped wave step, then the rho the next step will see
task automatic modelStep(input logic tension);
  longint nxt [`MESH_ROWS][`MESH_COLS];
  longint damp;
  longint lap;
  longint preSum;
  longint mid;
  damp = (longint'(1) <<< `FRAC_BITS) - mEta;           // 1 - eta
  for (int r = 0; r < `MESH_ROWS; r++) begin
    for (int c = 0; c < `MESH_COLS; c++) begin
      lap = cellAt(r - 1, c) + cellAt(r + 1, c) + cellAt(r, c - 1) + cellAt(r, c + 1)
          - 4 * mU[r][c];
      preSum = fixClip(mRho * lap) + 2 * mU[r][c] - fixClip(damp * mPrev[r][c]);
      nxt[r][c] = fixClip(preSum * damp);
    end
  end
  mPrev = mU;
  mU = nxt;
  mid = mU[`MESH_ROWS / 2][`MESH_COLS / 2];
  mRho = `RHO_0;
  if (tension) mRho = longint'(`RHO_0) + ((mid * mid) >>> `RHO_SHIFT);  // Stiffens with swing
  if (mRho > `RHO_MAX) mRho = `RHO_MAX;
endtask

function automatic sampleT modelSample();
  return sampleT'(mU[`MESH_ROWS / 2][`MESH_COLS / 2] >>> (`FRAC_BITS - 15));  // Top 16 bits
endfunction

task automatic checkSeg(input string name, input segT got, input segT exp);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("error %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic checkSample(input string name, input sampleT got, input sampleT exp);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("error %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("error %s: got %h, expected %h", name, got, exp);
  end
endtask

task automatic failNote(input string msg);
  errorCount++;
  $display("%s", msg);
endtask

`endif

// ==== verification/drumSynthTb.sv ====
`include "drumSynth_params.svh"

module drumSynthTb import meshPkg::*, ioPkg::*;;

  localparam int period = 8;
  localparam int toneRounds = 8;
  localparam int cadenceStrobes = 5;
  localparam int plainSteps = 40;
  localparam int tensionRunB = 24;
  localparam int strobeLimit = 2 * `MESH_STEP_DIV + 4;       // Covers press to first sample
  localparam int blinkLimit = (`BLINK_STEPS + 1) * `MESH_STEP_DIV + 4;
  // Rough clock budget of each test
  localparam int cycReset = 6;
  localparam int cycTone = toneRounds * 6;
  localparam int cycCadence = 4 + (cadenceStrobes + 3) * `MESH_STEP_DIV;
  localparam int cycPlain = 4 + (plainSteps + 3) * `MESH_STEP_DIV;
  localparam int cycTension = 8 + (23 + tensionRunB + 6) * `MESH_STEP_DIV;
  localparam int cycBlink = (3 * `BLINK_STEPS + 2) * `MESH_STEP_DIV;
  localparam int watchdogTime = 2 * period
                              * (cycReset + cycTone + cycCadence + cycPlain + cycTension + cycBlink);

  logic validOut;
  logic arstN;
  keyT keyN;
  logic tensionEn;
  segT hex0;
  segT hex1;
  segT hex2;
  segT hex3;
  segT hex4;
  sampleT audioSample;
  logic sampleStrobe;
  logic ledBlink;
  logic ledTone;
  logic [15:0] lfsrState = 16'd3122;
  int testCount;
  int markChecks;
  int markErrors;

  drumSynth drumSynth_inst (
    .validOut, .arstN, .keyN, .tensionEn,
    .hex0, .hex1, .hex2, .hex3, .hex4,
    .audioSample, .sampleStrobe, .ledBlink, .ledTone
  );

  `include "drumModel.svh"

  initial begin
    validOut = 1'b0;
    forever #(period / 2) validOut = ~validOut;
  end

  initial begin
    #(watchdogTime);
    $display("Watchdog expired after %0d time units, tests did not finish", watchdogTime);
    $display("TEST FAIL");
    $finish;
  end

  // Galois LFSR, one step per bit
  function automatic int takeBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsrState[0];
      lfsrState = {1'b0, lfsrState[15:1]} ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic int pickKey();
    return takeBits(2) % 3;                // Key index 0 to 2
  endfunction

  function automatic keyT keyFor(input int idx);
    return ~(3'b001 << idx);               // Active low
  endfunction

  function automatic coefT toneOf(input int idx);
    if (idx == 0) return `ETA_TONE1;
    if (idx == 1) return `ETA_TONE2;
    return `ETA_TONE3;
  endfunction

  task automatic checkEtaDigits(input coefT e);
    checkSeg("hex0", hex0, segFor(e[3:0]));
    checkSeg("hex1", hex1, segFor(e[7:4]));
    checkSeg("hex2", hex2, segFor(e[11:8]));
    checkSeg("hex3", hex3, segFor(e[15:12]));
    checkSeg("hex4", hex4, segFor({2'b00, e[17:16]}));
  endtask

  task automatic pressKeys(input keyT k, input logic tension);
    @(posedge validOut);
    keyN      <= k;
    tensionEn <= tension;
    @(negedge validOut);                   // Half a clock after the drive edge
  endtask

  task automatic releaseKeys(input logic tension);
    pressKeys(KEYS_UP, tension);
  endtask

  task automatic waitStrobe(output int clocks);
    clocks = 0;
    while (clocks < strobeLimit) begin
      @(negedge validOut);
      clocks++;
      if (sampleStrobe) return;
    end
    failNote($sformatf("No sampleStrobe within %0d clocks", strobeLimit));
  endtask

  // Press lands right after a sample, so no step falls between press and load
  task automatic pressAfterStrobe(input keyT k, input logic tension);
    int clocks;
    waitStrobe(clocks);
    pressKeys(k, tension);
  endtask

  task automatic runSteps(input int n, input logic tension);
    int clocks;
    for (int i = 0; i < n; i++) begin
      waitStrobe(clocks);
      modelStep(tension);
      checkSample("audioSample", audioSample, modelSample());
    end
  endtask

  task automatic waitBlink(output int strobes);
    logic last;
    int clocks;
    last = ledBlink;
    strobes = 0;
    clocks = 0;
    while (clocks < blinkLimit) begin
      @(negedge validOut);
      clocks++;
      if (sampleStrobe) strobes++;
      if (ledBlink != last) return;        // Toggle shares its edge with a strobe
    end
    failNote($sformatf("ledBlink did not toggle within %0d clocks", blinkLimit));
  endtask

  task automatic reportTest(input string name);
    testCount++;
    $display("%-14s %0d checks, %0d errors", name, checkCount - markChecks,
             errorCount - markErrors);
    markChecks = checkCount;
    markErrors = errorCount;
  endtask

  task automatic testReset();
    checkSample("audioSample", audioSample, 16'sh0000);
    checkBit("sampleStrobe", sampleStrobe, 1'b0);
    checkBit("ledBlink", ledBlink, 1'b0);
    checkBit("ledTone", ledTone, 1'b0);
    checkEtaDigits('0);                    // eta still zero
    reportTest("reset state");
  endtask

  task automatic testTonePriority();
    logic [2:0] mask;
    coefT exp;
    for (int i = 0; i < toneRounds; i++) begin
      mask = 3'(takeBits(3));
      if (mask == 3'b000) mask = 3'b100;   // Never an empty press
      exp = mask[0] ? `ETA_TONE1 : (mask[1] ? `ETA_TONE2 : `ETA_TONE3);
      releaseKeys(1'b0);
      @(negedge validOut);
      checkBit("ledTone", ledTone, 1'b0);
      pressKeys(~mask, 1'b0);
      @(negedge validOut);                 // eta and ledTone registered
      checkEtaDigits(exp);
      checkBit("ledTone", ledTone, 1'b1);
    end
    releaseKeys(1'b0);
    reportTest("tone priority");
  endtask

  task automatic testStepCadence();
    int clocks;
    releaseKeys(1'b0);
    pressAfterStrobe(keyFor(pickKey()), 1'b0);
    waitStrobe(clocks);
    if (clocks != `MESH_STEP_DIV + 2)
      failNote($sformatf("First sampleStrobe came %0d clocks after the press, expected %0d",
                         clocks, `MESH_STEP_DIV + 2));
    repeat (cadenceStrobes) begin
      waitStrobe(clocks);
      if (clocks != `MESH_STEP_DIV)
        failNote($sformatf("Strobes %0d clocks apart, expected %0d", clocks, `MESH_STEP_DIV));
    end
    reportTest("step cadence");
  endtask

  task automatic testPlainMesh();
    int idx;
    idx = pickKey();
    releaseKeys(1'b0);
    mRho = `RHO_0;                         // Tension has been off since reset
    pressAfterStrobe(keyFor(idx), 1'b0);
    modelLoad(toneOf(idx));
    runSteps(plainSteps, 1'b0);
    reportTest("plain mesh");
  endtask

  task automatic testTension();
    int idxA;
    int idxB;
    int runA;
    idxA = pickKey();
    runA = 8 + takeBits(4);
    releaseKeys(1'b0);
    pressAfterStrobe(keyFor(idxA), 1'b1);  // rhoEff still at base for step one
    modelLoad(toneOf(idxA));
    runSteps(runA, 1'b1);
    idxB = (idxA + 1 + takeBits(1)) % 3;   // Another key restarts mid-run
    pressKeys(keyFor(idxB), 1'b1);
    modelLoad(toneOf(idxB));
    runSteps(tensionRunB, 1'b1);
    releaseKeys(1'b0);
    reportTest("tension");
  endtask

  task automatic testBlink();
    int strobes;
    waitBlink(strobes);                    // Sync to a toggle
    repeat (2) begin
      waitBlink(strobes);
      if (strobes != `BLINK_STEPS)
        failNote($sformatf("ledBlink toggled after %0d strobes, expected %0d",
                           strobes, `BLINK_STEPS));
    end
    reportTest("blink");
  endtask

  initial begin
    keyN      = KEYS_UP;
    tensionEn = 1'b0;
    arstN     = 1'b0;
    repeat (3) @(posedge validOut);
    arstN <= 1'b1;
    @(negedge validOut);
    testReset();
    testTonePriority();
    testStepCadence();
    testPlainMesh();
    testTension();
    testBlink();
    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
